//--- Bender.yml
package:
  name: pulse_sequencer

sources:
  - src/pulse_pkg.sv
  - src/pulse_if.sv
  - src/param_latch.sv
  - src/period_timer.sv
  - src/echo_sequencer.sv
  - src/gate_shaper.sv
  - src/pulse_top.sv
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/pulse_props.sv
      - verification/pulse_tb.sv

//--- flist.f
src/pulse_pkg.sv
src/pulse_if.sv
src/param_latch.sv
src/period_timer.sv
src/echo_sequencer.sv
src/gate_shaper.sv
src/pulse_top.sv
verification/tb_clock.sv
verification/pulse_props.sv
verification/pulse_tb.sv

//--- src/echo_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module echo_sequencer #(
	parameter int COUNT_W = 32
) (
	input  logic                  clk,
	input  logic                  reset,
	input  pulse_pkg::pulse_cfg_t cfg,
	pulse_if.seq                  seq
);
	import pulse_pkg::*;

	seq_mode_e          mode;
	seq_state_e         state;
	seq_state_e         state_nxt;
	logic [CNT_W_W-1:0] pi_idx;    // pi pulse in progress
	logic [CNT_W_W-1:0] win_idx;   // echo window in progress
	logic [CNT_W_W-1:0] last_idx;
	logic [COUNT_W-1:0] pi_start;  // next edge times
	logic [COUNT_W-1:0] pi_end;
	logic [COUNT_W-1:0] win_start;
	logic [COUNT_W-1:0] win_end;
	logic [COUNT_W-1:0] p1;
	logic [COUNT_W-1:0] first_pi_start;
	logic [COUNT_W-1:0] first_pi_end;
	logic [COUNT_W-1:0] first_win_start;
	logic [COUNT_W-1:0] first_win_end;
	logic [COUNT_W-1:0] step;      // spacing of the pi train
	logic               pulsed;
	logic               pump;
	logic               wrap;
	logic               reload;
	logic               in_sched;
	logic               pi_on;
	logic               pi_done;
	logic               last_pi;
	logic               win_act;
	logic               win_on;
	logic               win_done;

	always_comb begin
		if (cfg.pi_count == '0)
			mode = mode_cw;
		else if (cfg.pi_count == CNT_W_W'(1))
			mode = mode_hahn;
		else
			mode = mode_cpmg;
	end

	assign p1             = COUNT_W'(cfg.p1_width);
	assign step           = (COUNT_W'(cfg.delay) << 1) + COUNT_W'(cfg.p2_width);
	assign first_pi_start = p1 + COUNT_W'(cfg.delay);
	assign first_pi_end   = first_pi_start + COUNT_W'(cfg.p2_width);

	// hahn window sits just before the echo, cpmg window follows each pulse
	assign first_win_end = (mode == mode_hahn) ?
		first_pi_end + COUNT_W'(cfg.delay) :
		first_pi_end + COUNT_W'(cfg.blank_hold) + COUNT_W'(cfg.window_len);
	assign first_win_start = (mode == mode_hahn) ?
		first_pi_end + COUNT_W'(cfg.delay) - COUNT_W'(cfg.blank_hold) :
		first_pi_end + COUNT_W'(cfg.blank_hold);

	assign pulsed   = (mode != mode_cw);
	assign pump     = seq.count < p1;
	assign wrap     = seq.count >= COUNT_W'(cfg.period); // last cycle of the frame
	assign reload   = (state == st_pump) || (state == st_cw);
	assign in_sched = (state == st_gap) || (state == st_pi) || (state == st_tail);
	assign last_idx = cfg.pi_count - CNT_W_W'(1);
	assign last_pi  = (pi_idx == last_idx);
	assign pi_done  = (state == st_pi) && (seq.count >= pi_end);
	assign pi_on    = ((state == st_gap) || (state == st_pi)) &&
		(seq.count >= pi_start) && (seq.count < pi_end);
	assign win_act  = in_sched && (win_idx < cfg.pi_count);
	assign win_on   = win_act && (seq.count >= win_start) && (seq.count < win_end);
	assign win_done = win_act && (seq.count >= win_end);

	always_comb begin
		state_nxt = state;
		case (state)
			st_pump: begin
				if (!pulsed)
					state_nxt = st_cw;
				else if (!pump)
					state_nxt = st_gap; // edges loaded on this clock too
			end
			st_gap:  if (seq.count >= pi_start) state_nxt = st_pi;
			st_pi:   if (pi_done) state_nxt = last_pi ? st_tail : st_gap;
			st_tail: state_nxt = st_tail; // idle till the wrap
			st_cw:   if (pulsed) state_nxt = st_pump;
			default: state_nxt = st_pump;
		endcase
		if (wrap)
			state_nxt = pulsed ? st_pump : st_cw;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= st_pump;
			pi_idx  <= '0;
			win_idx <= '0;
		end else begin
			state <= state_nxt;
			if (reload) begin
				pi_idx  <= '0;
				win_idx <= '0;
			end else begin
				if (pi_done)  pi_idx  <= pi_idx + CNT_W_W'(1);
				if (win_done) win_idx <= win_idx + CNT_W_W'(1);
			end
		end
	end

	// edge times, reloaded through the whole pump so a fresh commit is picked up
	always_ff @(posedge clk) begin
		if (reload) begin
			pi_start  <= first_pi_start;
			pi_end    <= first_pi_end;
			win_start <= first_win_start;
			win_end   <= first_win_end;
		end else begin
			if (pi_done) begin
				pi_start <= pi_start + step;
				pi_end   <= pi_end + step;
			end
			if (win_done) begin
				win_start <= win_start + step;
				win_end   <= win_end + step;
			end
		end
	end

	assign seq.mode      = mode;
	assign seq.pi_gate   = pulsed ? (pump | pi_on) : 1'b1;
	assign seq.trig_gate = pulsed ? ((state != st_tail) && !(pi_done && last_pi)) : pump;
	assign seq.echo_win  = pulsed ? win_on : 1'b1; // cw keeps the receiver open

endmodule

`default_nettype wire

//--- src/gate_shaper.sv
`timescale 1ns/100ps
`default_nettype none

module gate_shaper #(
	parameter int COUNT_W = 32
) (
	input  logic                  clk,
	input  logic                  reset,
	input  pulse_pkg::pulse_cfg_t cfg,
	pulse_if.shaper               shp,
	output logic                  sync_on,
	output logic                  pulse_on,
	output logic                  inhib
);
	import pulse_pkg::*;

	logic [COUNT_W-1:0] nut_start; // nutation window, counted back from the period
	logic [COUNT_W-1:0] nut_stop;
	logic               nut_armed; // one nutation pulse per frame
	logic               nut_on;
	logic               blank_en;

	// bounds trail cfg by a clock, the window is near the frame end anyway
	always_ff @(posedge clk) begin
		nut_stop  <= COUNT_W'(cfg.period) - COUNT_W'(cfg.nut_delay);
		nut_start <= COUNT_W'(cfg.period) - COUNT_W'(cfg.nut_delay) -
			COUNT_W'(cfg.nut_width);
	end

	always_ff @(posedge clk) begin
		if (reset)
			nut_armed <= 1'b0;
		else if (shp.frame_start)
			nut_armed <= 1'b1;
		else if (shp.count >= nut_stop)
			nut_armed <= 1'b0; // spent for this frame
	end

	assign nut_on = nut_armed && (cfg.nut_width != '0) &&
		(shp.count >= nut_start) && (shp.count < nut_stop);

	// no blanking in cw, receiver is always open there
	assign blank_en = cfg.block_en && (shp.mode != mode_cw);

	always_ff @(posedge clk) begin
		if (reset) begin
			sync_on  <= 1'b0;
			pulse_on <= 1'b0;
			inhib    <= 1'b0;
		end else begin
			sync_on  <= shp.trig_gate;
			pulse_on <= shp.pi_gate | nut_on;      // nutation ORed onto the switch
			inhib    <= blank_en & ~shp.echo_win; // closed except in the windows
		end
	end

endmodule

`default_nettype wire

//--- src/param_latch.sv
`timescale 1ns/100ps
`default_nettype none

module param_latch (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            rxd,      // load level from the host
	input  logic [pulse_pkg::PER_W-1:0]     per,
	input  logic [pulse_pkg::P1_W-1:0]      p1wid,
	input  logic [pulse_pkg::DLY_W-1:0]     del,
	input  logic [pulse_pkg::P1_W-1:0]      p2wid,
	input  logic [pulse_pkg::NUT_W_W-1:0]   nut_w,
	input  logic [pulse_pkg::DLY_W-1:0]     nut_d,
	input  logic [pulse_pkg::CNT_W_W-1:0]   cp,
	input  logic [pulse_pkg::CNT_W_W-1:0]   p_bl,
	input  logic [pulse_pkg::DLY_W-1:0]     p_bl_off,
	input  logic                            bl,
	input  logic                            frame_start,
	output pulse_pkg::pulse_cfg_t           cfg
);
	import pulse_pkg::*;

	// default frame is a hahn echo, 1024 cycles
	localparam pulse_cfg_t CFG_DEFAULT = '{
		period:     PER_W'(1023),
		p1_width:   P1_W'(30),
		delay:      DLY_W'(200),
		p2_width:   P1_W'(30),
		nut_width:  NUT_W_W'(0),
		nut_delay:  DLY_W'(300),
		pi_count:   CNT_W_W'(1),
		blank_hold: CNT_W_W'(50),
		window_len: DLY_W'(100),
		block_en:   1'b1
	};

	logic [1:0] rxd_sync; // two stage synchronizer
	logic       rxd_q;    // delayed copy for edge detect
	logic       load;
	pulse_cfg_t shadow;   // captured words, wait here for the frame boundary

	always_ff @(posedge clk) begin
		if (reset) begin
			rxd_sync <= '0;
			rxd_q    <= 1'b0;
		end else begin
			rxd_sync <= {rxd_sync[0], rxd};
			rxd_q    <= rxd_sync[1];
		end
	end

	assign load = rxd_sync[1] & ~rxd_q; // rising edge of the synced level

	always_ff @(posedge clk) begin
		if (reset) begin
			shadow <= CFG_DEFAULT;
			cfg    <= CFG_DEFAULT;
		end else begin
			if (load) begin
				shadow <= '{
					period:     per,
					p1_width:   p1wid,
					delay:      del,
					p2_width:   p2wid,
					nut_width:  nut_w,
					nut_delay:  nut_d,
					pi_count:   cp,
					blank_hold: p_bl,
					window_len: p_bl_off,
					block_en:   bl
				};
			end
			if (frame_start)
				cfg <= shadow; // old shadow wins if load lands on the same clock
		end
	end

endmodule

`default_nettype wire

//--- src/period_timer.sv
`timescale 1ns/100ps
`default_nettype none

module period_timer #(
	parameter int COUNT_W = 32
) (
	input  logic                  clk,
	input  logic                  reset,
	input  pulse_pkg::pulse_cfg_t cfg,
	pulse_if.timer                tmr
);

	logic [COUNT_W-1:0] last; // final count of the frame

	assign last = COUNT_W'(cfg.period);

	always_ff @(posedge clk) begin
		if (reset) begin
			tmr.count <= '0;
		end else if (tmr.count >= last) begin
			tmr.count <= '0; // also catches a period shortened below the count
		end else begin
			tmr.count <= tmr.count + COUNT_W'(1);
		end
	end

	// every schedule is measured from here
	assign tmr.frame_start = (tmr.count == '0);

endmodule

`default_nettype wire

//--- src/pulse_if.sv
`timescale 1ns/100ps
`default_nettype none

interface pulse_if #(
	parameter int COUNT_W = 32
);
	import pulse_pkg::*;

	logic [COUNT_W-1:0] count;       // position inside the frame
	logic               frame_start; // high while count is 0
	logic               pi_gate;     // pump and pi pulses, or cw level
	logic               trig_gate;   // scope trigger before registering
	logic               echo_win;    // receiver window open
	seq_mode_e          mode;

	modport timer (
		output count,
		output frame_start
	);

	modport seq (
		input  count,
		output pi_gate,
		output trig_gate,
		output echo_win,
		output mode
	);

	// shaper sees everything
	modport shaper (
		input count,
		input frame_start,
		input pi_gate,
		input trig_gate,
		input echo_win,
		input mode
	);

endinterface

`default_nettype wire

//--- src/pulse_pkg.sv
`default_nettype none

package pulse_pkg;

	localparam int PER_W   = 32; // period word, cycles per frame minus one
	localparam int P1_W    = 16; // pump and pi pulse widths
	localparam int DLY_W   = 16; // delay, nutation offset, window length
	localparam int NUT_W_W = 8;  // nutation pulse width
	localparam int CNT_W_W = 8;  // pi pulse count and blanking hold

	// derived from the pi pulse count
	typedef enum logic [1:0] {
		mode_cw,   // switch held open, receiver open
		mode_hahn, // one pi pulse, window at the echo
		mode_cpmg  // pi pulse train, window after each pulse
	} seq_mode_e;

	typedef enum logic [2:0] {
		st_pump, // pump pulse, first edges being loaded
		st_gap,  // waiting for the next pi pulse
		st_pi,   // inside a pi pulse
		st_tail, // all pi pulses done, rest of the frame
		st_cw    // continuous wave
	} seq_state_e;

	// active settings, all times in clock cycles
	typedef struct packed {
		logic [PER_W-1:0]   period;
		logic [P1_W-1:0]    p1_width;
		logic [DLY_W-1:0]   delay;
		logic [P1_W-1:0]    p2_width;
		logic [NUT_W_W-1:0] nut_width;
		logic [DLY_W-1:0]   nut_delay;  // gap between nutation pulse and frame end
		logic [CNT_W_W-1:0] pi_count;
		logic [CNT_W_W-1:0] blank_hold; // receiver kept blanked after a pi pulse
		logic [DLY_W-1:0]   window_len;
		logic               block_en;
	} pulse_cfg_t;

endpackage

`default_nettype wire

//--- src/pulse_top.sv
`timescale 1ns/100ps
`default_nettype none

module pulse_top #(
	parameter int COUNT_W = 32
) (
	input  logic                          clk,
	input  logic                          reset,
	input  logic [pulse_pkg::PER_W-1:0]   per,
	input  logic [pulse_pkg::P1_W-1:0]    p1wid,
	input  logic [pulse_pkg::DLY_W-1:0]   del,
	input  logic [pulse_pkg::P1_W-1:0]    p2wid,
	input  logic [pulse_pkg::NUT_W_W-1:0] nut_w,
	input  logic [pulse_pkg::DLY_W-1:0]   nut_d,
	input  logic [pulse_pkg::CNT_W_W-1:0] cp,
	input  logic [pulse_pkg::CNT_W_W-1:0] p_bl,
	input  logic [pulse_pkg::DLY_W-1:0]   p_bl_off,
	input  logic                          bl,
	input  logic                          rxd,
	output logic                          sync_on,  // scope trigger
	output logic                          pulse_on, // switch gate
	output logic                          inhib     // receiver protection
);
	import pulse_pkg::*;

	pulse_cfg_t cfg; // active settings, same copy to every block

	pulse_if #(.COUNT_W(COUNT_W)) p_if ();

	param_latch i_latch (
		.clk         (clk),
		.reset       (reset),
		.rxd         (rxd),
		.per         (per),
		.p1wid       (p1wid),
		.del         (del),
		.p2wid       (p2wid),
		.nut_w       (nut_w),
		.nut_d       (nut_d),
		.cp          (cp),
		.p_bl        (p_bl),
		.p_bl_off    (p_bl_off),
		.bl          (bl),
		.frame_start (p_if.frame_start),
		.cfg         (cfg)
	);

	period_timer #(.COUNT_W(COUNT_W)) i_timer (
		.clk   (clk),
		.reset (reset),
		.cfg   (cfg),
		.tmr   (p_if.timer)
	);

	echo_sequencer #(.COUNT_W(COUNT_W)) i_seq (
		.clk   (clk),
		.reset (reset),
		.cfg   (cfg),
		.seq   (p_if.seq)
	);

	gate_shaper #(.COUNT_W(COUNT_W)) i_shaper (
		.clk      (clk),
		.reset    (reset),
		.cfg      (cfg),
		.shp      (p_if.shaper),
		.sync_on  (sync_on),
		.pulse_on (pulse_on),
		.inhib    (inhib)
	);

endmodule

`default_nettype wire

//--- verification/pulse_props.sv
`timescale 1ns/100ps
`default_nettype none

module pulse_props (
	input logic clk,
	input logic reset,
	input logic sync_on,
	input logic pulse_on,
	input logic inhib,
	input logic frame_start, // count is 0
	input logic pi_on,       // sequencer inside a pi pulse
	input logic blank_en     // blanking active in this mode
);

	logic sync_q;
	logic sync_fell;
	logic fell_seen; // sync_on already fell in this frame
	int   fail_cnt;  // failed assertion count

	always_ff @(posedge clk) begin
		if (reset) begin
			sync_q    <= 1'b0;
			fell_seen <= 1'b0;
		end else begin
			sync_q <= sync_on;
			if (frame_start)
				fell_seen <= 1'b0;
			else if (sync_fell)
				fell_seen <= 1'b1;
		end
	end

	assign sync_fell = sync_q & ~sync_on;

	// receiver window never open while a pi pulse drives the switch
	pi_blanked: assert property (@(posedge clk) disable iff (reset)
		pi_on && blank_en |=> inhib)
	else begin
		$error("receiver window open during a pi pulse");
		fail_cnt++;
	end

	out_reset: assert property (@(posedge clk) $past(reset) |-> !sync_on && !pulse_on && !inhib)
	else begin
		$error("outputs not low after reset");
		fail_cnt++;
	end

	one_fall: assert property (@(posedge clk) disable iff (reset) sync_fell |-> !fell_seen)
	else begin
		$error("sync_on fell twice within one frame");
		fail_cnt++;
	end

endmodule

bind pulse_top pulse_props i_props (
	.clk         (clk),
	.reset       (reset),
	.sync_on     (sync_on),
	.pulse_on    (pulse_on),
	.inhib       (inhib),
	.frame_start (p_if.frame_start),
	.pi_on       (i_seq.pi_on),
	.blank_en    (i_shaper.blank_en)
);

`default_nettype wire

//--- verification/pulse_tb.sv
`timescale 1ns/100ps
`default_nettype none

module pulse_tb;
	import pulse_pkg::*;

	localparam int N_CPMG  = 4;
	localparam int N_NUT   = 2;
	localparam int N_MID   = 2;
	localparam int N_LOADS = 1 + N_CPMG + N_NUT + N_MID;
	// each load waits up to a frame for its slot and then three frames of at most 2001 cycles
	localparam int TIMEOUT_CYCLES = 16 + 4 * 1024 + N_LOADS * (4 * 2001 + 8) + 2000;

	logic                clk;
	logic                reset;
	logic [PER_W-1:0]    per;
	logic [P1_W-1:0]     p1wid;
	logic [DLY_W-1:0]    del;
	logic [P1_W-1:0]     p2wid;
	logic [NUT_W_W-1:0]  nut_w;
	logic [DLY_W-1:0]    nut_d;
	logic [CNT_W_W-1:0]  cp;
	logic [CNT_W_W-1:0]  p_bl;
	logic [DLY_W-1:0]    p_bl_off;
	logic                bl;
	logic                rxd;
	logic                sync_on;
	logic                pulse_on;
	logic                inhib;

	pulse_cfg_t dflt;       // settings after reset
	pulse_cfg_t act;        // model settings of the running frame
	pulse_cfg_t prv;        // count 0 still runs on the previous settings
	pulse_cfg_t pend;       // loaded and waiting for the wrap
	pulse_cfg_t cur;
	pulse_cfg_t next_cfg;
	bit         pend_valid;
	bit         locked;     // model count aligned to the DUT
	int         phase;      // count whose gates the outputs show now
	int         wraps;
	int         err_sync;
	int         err_pulse;
	int         err_inhib;
	int         err_reset;
	int         i;
	int         n_pi;
	int         blk;
	int         nut;
	int         slot;

	tb_clock #(.PERIOD(8), .RESET_CYCLES(16)) i_clock (.clk(clk), .reset(reset));

	pulse_top i_dut (
		.clk(clk), .reset(reset), .per(per), .p1wid(p1wid), .del(del), .p2wid(p2wid),
		.nut_w(nut_w), .nut_d(nut_d), .cp(cp), .p_bl(p_bl), .p_bl_off(p_bl_off),
		.bl(bl), .rxd(rxd), .sync_on(sync_on), .pulse_on(pulse_on), .inhib(inhib)
	);

	// scope trigger covers the first p1 cycles in cw and runs to the last pi pulse end otherwise
	function automatic bit trigger_level(input pulse_cfg_t c, input int t);
		int p1;
		int d;
		int p2;
		int n;
		p1 = c.p1_width;
		d  = c.delay;
		p2 = c.p2_width;
		n  = c.pi_count;
		if (n == 0)
			return t < p1;
		return t < p1 + d + (n - 1) * (2 * d + p2) + p2;
	endfunction

	// switch gate from the pump, the pi pulses and the nutation pulse near the frame end
	function automatic bit switch_level(input pulse_cfg_t c, input int t);
		int p1;
		int d;
		int p2;
		int n;
		int k;
		int nw;
		int nd;
		int prd;
		bit on;
		p1  = c.p1_width;
		d   = c.delay;
		p2  = c.p2_width;
		n   = c.pi_count;
		nw  = c.nut_width;
		nd  = c.nut_delay;
		prd = c.period;
		if (n == 0)
			return 1'b1; // cw holds the switch open
		on = (t < p1);
		for (k = 0; k < n; k++)
			if (t >= p1 + d + k * (2 * d + p2) && t < p1 + d + k * (2 * d + p2) + p2)
				on = 1'b1;
		if (nw != 0 && t >= prd - nd - nw && t < prd - nd)
			on = 1'b1;
		return on;
	endfunction

	// receiver protection stays high unless an echo window is open
	function automatic bit blanking_level(input pulse_cfg_t c, input int t);
		int p1;
		int d;
		int p2;
		int n;
		int k;
		int bh;
		int wl;
		int ek;
		bit open;
		p1 = c.p1_width;
		d  = c.delay;
		p2 = c.p2_width;
		n  = c.pi_count;
		bh = c.blank_hold;
		wl = c.window_len;
		open = 1'b0;
		if (n == 0) begin
			open = 1'b1;
		end else if (n == 1) begin
			open = (t >= p1 + 2 * d + p2 - bh) && (t < p1 + 2 * d + p2); // at the echo
		end else begin
			for (k = 0; k < n; k++) begin
				ek = p1 + d + k * (2 * d + p2) + p2;
				if (t >= ek + bh && t < ek + bh + wl)
					open = 1'b1;
			end
		end
		return c.block_en && !open;
	endfunction

	task automatic draw_settings(input int n, input bit blk_en, input bit with_nut,
			output pulse_cfg_t c);
		int p1;
		int d;
		int p2;
		int bh;
		int sched_end;
		int prd;
		p1 = $urandom_range(30, 5);
		d  = $urandom_range(60, 20);
		p2 = $urandom_range(30, 5);
		bh = $urandom_range(d / 2, 2);
		c = '0;
		c.p1_width   = p1;
		c.delay      = d;
		c.p2_width   = p2;
		c.blank_hold = bh;
		c.window_len = $urandom_range(2 * d - bh, 5); // closes before the next pi pulse
		c.pi_count   = n;
		c.block_en   = blk_en;
		c.nut_width  = with_nut ? $urandom_range(60, 1) : 0;
		c.nut_delay  = $urandom_range(30, 0);
		// train, last window and nutation pulse all fit in the frame
		sched_end = p1 + d + n * (2 * d + p2) + 2 * d + 100;
		prd = $urandom_range(2000, 300);
		c.period = (prd < sched_end) ? sched_end : prd;
	endtask

	// drive the words and pulse rxd once the model count reaches the given count
	task automatic load_settings(input pulse_cfg_t c, input int at);
		@(posedge clk);
		while (phase != at) @(posedge clk);
		per      <= c.period;
		p1wid    <= c.p1_width;
		del      <= c.delay;
		p2wid    <= c.p2_width;
		nut_w    <= c.nut_width;
		nut_d    <= c.nut_delay;
		cp       <= c.pi_count;
		p_bl     <= c.blank_hold;
		p_bl_off <= c.window_len;
		bl       <= c.block_en;
		rxd      <= 1'b1;
		pend       = c;
		pend_valid = 1'b1; // takes over at the next wrap
		repeat (4) @(posedge clk);
		rxd <= 1'b0;
	endtask

	task automatic wait_frames(input int n);
		int stop_at;
		stop_at = wraps + n;
		while (wraps < stop_at) @(posedge clk);
	endtask

	// model and checks run on the falling edge where outputs are settled
	always @(negedge clk) begin
		if (reset) begin
			locked = 1'b0;
			if (sync_on !== 1'b0 || pulse_on !== 1'b0 || inhib !== 1'b0) begin
				err_reset++;
				$display("Mismatch at %0t: outputs not low during reset", $time);
			end
		end else if (!locked) begin
			if (sync_on === 1'b1) begin // trigger rises at count 0
				locked = 1'b1;
				phase  = 0;
				act    = dflt;
				prv    = dflt;
			end
		end else if (phase == act.period) begin
			phase = 0;
			prv   = act;
			wraps++;
			if (pend_valid) begin
				act        = pend;
				pend_valid = 1'b0;
			end
		end else begin
			phase++;
		end
		if (locked && !reset) begin
			cur = (phase == 0) ? prv : act;
			if (sync_on !== trigger_level(cur, phase)) begin
				err_sync++;
				$display("Mismatch at %0t: sync_on is %b at count %0d", $time, sync_on, phase);
			end
			if (pulse_on !== switch_level(cur, phase)) begin
				err_pulse++;
				$display("Mismatch at %0t: pulse_on is %b at count %0d", $time, pulse_on, phase);
			end
			if (inhib !== blanking_level(cur, phase)) begin
				err_inhib++;
				$display("Mismatch at %0t: inhib is %b at count %0d", $time, inhib, phase);
			end
		end
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("Timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		void'($urandom(32'h4c20));
		dflt = '0;
		dflt.period     = 1023; // hahn echo with a 1024 cycle frame
		dflt.p1_width   = 30;
		dflt.delay      = 200;
		dflt.p2_width   = 30;
		dflt.nut_delay  = 300;
		dflt.pi_count   = 1;
		dflt.blank_hold = 50;
		dflt.window_len = 100;
		dflt.block_en   = 1'b1;
		per      = '0;
		p1wid    = '0;
		del      = '0;
		p2wid    = '0;
		nut_w    = '0;
		nut_d    = '0;
		cp       = '0;
		p_bl     = '0;
		p_bl_off = '0;
		bl       = 1'b0;
		rxd      = 1'b0;
		pend_valid = 1'b0;
		while (!locked) @(posedge clk);
		wait_frames(3);
		draw_settings(0, 1'b1, 1'b0, next_cfg); // cw with blanking enabled but unused
		load_settings(next_cfg, act.period / 2);
		wait_frames(3);
		for (i = 0; i < N_CPMG; i++) begin
			n_pi = $urandom_range(6, 2);
			draw_settings(n_pi, 1'b1, 1'b0, next_cfg);
			load_settings(next_cfg, act.period / 2);
			wait_frames(3);
		end
		for (i = 0; i < N_NUT; i++) begin
			n_pi = $urandom_range(3, 1);
			draw_settings(n_pi, 1'b0, 1'b1, next_cfg); // nutation without blanking
			load_settings(next_cfg, act.period / 2);
			wait_frames(3);
		end
		for (i = 0; i < N_MID; i++) begin
			n_pi = $urandom_range(4, 0);
			blk  = $urandom_range(1, 0);
			nut  = $urandom_range(1, 0);
			draw_settings(n_pi, blk, nut, next_cfg);
			slot = $urandom_range(act.period * 3 / 4, act.period / 4);
			load_settings(next_cfg, slot);
			wait_frames(3);
		end
		$display("errors: sync_on %0d, pulse_on %0d, inhib %0d, reset %0d, assertions %0d",
			err_sync, err_pulse, err_inhib, err_reset, i_dut.i_props.fail_cnt);
		if (err_sync + err_pulse + err_inhib + err_reset + i_dut.i_props.fail_cnt == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD       = 8,  // ns
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0; // released on a rising edge like every other input
	end

endmodule

`default_nettype wire
